/* hw/asg_settings.svh */
/* widths for the periodic generator; the table holds 2**ASG_CWM samples and
   its APB window at TBL must fit below 2**ASG_AW */
`ifndef ASG_SETTINGS_SVH
`define ASG_SETTINGS_SVH

`default_nettype none

////////////////////////////////////////////////////////////////////////////
// phase pointer, fixed point u(CWM).(CWF)
////////////////////////////////////////////////////////////////////////////

// integer part, also the table index width
`define ASG_CWM 10
// fraction part
`define ASG_CWF 8

////////////////////////////////////////////////////////////////////////////
// data and bus widths
////////////////////////////////////////////////////////////////////////////

// one waveform sample
`define ASG_DW 14
// APB byte address
`define ASG_AW 12

`default_nettype wire

`endif

/* hw/asg_pkg.sv */
/* types shared by the generator blocks; the register offsets assume
   ASG_AW = 12 with the table window at 'h400 */
`include "asg_settings.svh"
`default_nettype none

package asg_pkg;

  // fixed point pointer, magnitude above fraction
  typedef logic [`ASG_CWM+`ASG_CWF-1:0] ptr_t;
  // table index
  typedef logic [`ASG_CWM-1:0] tbl_adr_t;
  // one sample
  typedef logic [`ASG_DW-1:0] smp_t;
  // APB address
  typedef logic [`ASG_AW-1:0] apb_adr_t;

  // single cycle event strobes, bit order as in CTL
  typedef struct packed {
    logic trg;
    logic stp;
    logic str;
    logic rst;
  } evn_t;

  // periodic mode configuration
  typedef struct packed {
    ptr_t siz;
    ptr_t ste;
    ptr_t off;
  } cfg_t;

  // pointer generator to table
  typedef struct packed {
    logic     valid;
    logic     last;
    tbl_adr_t adr;
  } adr_stm_t;

  // table to output
  typedef struct packed {
    logic valid;
    logic last;
    smp_t dat;
  } smp_stm_t;

  // register offsets, TBL is the base of the write-only table window
  typedef enum apb_adr_t {
    CTL = 'h000,
    SIZ = 'h004,
    STE = 'h008,
    OFF = 'h00c,
    STS = 'h010,
    TBL = 'h400
  } reg_adr_e;

endpackage

`default_nettype wire

/* hw/asg_apb_regs.sv */
/* APB configuration slave with zero wait states; CTL bits 0..3 are the rst,
   str, stp and trg strobes and the table window is write-only */
`include "asg_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module asg_apb_regs import asg_pkg::*; (
  input  logic        sto,
  input  logic        rst_n,
  // APB slave
  input  apb_adr_t    paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  // external trigger
  input  logic        trg,
  // status from the pointer generator
  input  logic        sts_str,
  input  logic        sts_swt,
  // configuration and events
  output cfg_t        cfg,
  output evn_t        evn,
  // table write port
  output logic        tbl_we,
  output tbl_adr_t    tbl_adr,
  output smp_t        tbl_dat
);

  localparam apb_adr_t TBL_BASE = TBL;

  logic acc;
  logic wr;
  logic tbl_hit;
  logic reg_hit;
  evn_t evn_q;

  ////////////////////////////////////////////////////////////////////////////
  // access decode
  ////////////////////////////////////////////////////////////////////////////

  // access phase of a transfer
  assign acc = psel & penable;
  assign wr  = acc & pwrite;

  // upper bits select the table window
  assign tbl_hit = (paddr[`ASG_AW-1:`ASG_CWM] == TBL_BASE[`ASG_AW-1:`ASG_CWM]);

  // no wait states
  assign pready  = 1'b1;
  assign pslverr = acc & ~(reg_hit | tbl_hit);

  ////////////////////////////////////////////////////////////////////////////
  // configuration and events
  ////////////////////////////////////////////////////////////////////////////

  // config survives a soft reset
  always_ff @(posedge sto) begin
    if (!rst_n) begin
      cfg <= '0;
    end else if (wr) begin
      if (paddr == SIZ) cfg.siz <= pwdata[$bits(ptr_t)-1:0];
      if (paddr == STE) cfg.ste <= pwdata[$bits(ptr_t)-1:0];
      if (paddr == OFF) cfg.off <= pwdata[$bits(ptr_t)-1:0];
    end
  end

  // strobes live for one cycle after the CTL write
  always_ff @(posedge sto) begin
    if (!rst_n) begin
      evn_q <= '0;
    end else if (wr && (paddr == CTL)) begin
      evn_q <= evn_t'(pwdata[$bits(evn_t)-1:0]);
    end else begin
      evn_q <= '0;
    end
  end

  // external trigger merged here
  always_comb begin
    evn     = evn_q;
    evn.trg = evn_q.trg | trg;
  end

  // table writes go straight through
  assign tbl_we  = wr & tbl_hit;
  assign tbl_adr = paddr[`ASG_CWM-1:0];
  assign tbl_dat = pwdata[`ASG_DW-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // readback
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    reg_hit = 1'b1;
    prdata  = '0;
    case (paddr)
      CTL: prdata = '0;
      SIZ: prdata = 32'(cfg.siz);
      STE: prdata = 32'(cfg.ste);
      OFF: prdata = 32'(cfg.off);
      STS: prdata = {30'd0, sts_swt, sts_str};
      // unmapped, unless inside the table window
      default: reg_hit = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* hw/asg_per.sv */
/* periodic mode only; triggers during a run are ignored and after a stop the
   run ends once the beat marked last has been accepted */
`include "asg_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module asg_per import asg_pkg::*; (
  input  logic     sto,
  input  logic     rst_n,
  input  evn_t     evn,
  input  cfg_t     cfg,
  output adr_stm_t adr_stm,
  input  logic     adr_rdy,
  output logic     sts_str,
  output logic     sts_swt
);

  localparam int unsigned PW = $bits(ptr_t);

  ptr_t        ptr_cur;
  // one extra bit for the borrow
  logic [PW:0] ptr_nxt;
  logic [PW:0] ptr_sub;
  logic        ptr_neg;
  logic        ctl_run;
  logic        ctl_end;
  logic        lst_pnd;

  ////////////////////////////////////////////////////////////////////////////
  // start/stop and run status
  ////////////////////////////////////////////////////////////////////////////

  // trigger while started or together with start, idle only
  assign ctl_run = evn.trg & (sts_str | evn.str) & ~evn.stp & ~sts_swt;

  // current beat is the final one
  assign ctl_end = sts_swt & (evn.stp | lst_pnd);

  always_ff @(posedge sto) begin
    if (!rst_n) begin
      sts_str <= 1'b0;
      sts_swt <= 1'b0;
      lst_pnd <= 1'b0;
    end else if (evn.rst) begin
      sts_str <= 1'b0;
      sts_swt <= 1'b0;
      lst_pnd <= 1'b0;
    end else begin
      // stop wins over start
      if (evn.stp)      sts_str <= 1'b0;
      else if (evn.str) sts_str <= 1'b1;
      // run ends when the last beat is taken
      if (ctl_end && adr_rdy) sts_swt <= 1'b0;
      else if (ctl_run)       sts_swt <= 1'b1;
      // stop seen but last beat still stalled
      lst_pnd <= ctl_end & ~adr_rdy;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // modulo phase pointer
  ////////////////////////////////////////////////////////////////////////////

  assign ptr_nxt = {1'b0, ptr_cur} + ({1'b0, cfg.ste} + 1'b1);
  assign ptr_sub = ptr_nxt - ({1'b0, cfg.siz} + 1'b1);
  // borrow set, no wrap needed
  assign ptr_neg = ptr_sub[PW];

  always_ff @(posedge sto) begin
    if (!rst_n) begin
      ptr_cur <= '0;
    end else if (evn.rst) begin
      ptr_cur <= '0;
    end else if (ctl_run) begin
      ptr_cur <= cfg.off;
    end else if (sts_swt && adr_rdy) begin
      // advance on accepted beat only
      ptr_cur <= ptr_neg ? ptr_nxt[PW-1:0] : ptr_sub[PW-1:0];
    end
  end

  // integer part addresses the table
  assign adr_stm.valid = sts_swt;
  assign adr_stm.last  = ctl_end;
  assign adr_stm.adr   = ptr_cur[PW-1 -: `ASG_CWM];

endmodule

`default_nettype wire

/* hw/asg_table.sv */
/* single port write from APB, registered read; one address and one sample
   can be in flight, clr drops a held sample */
`include "asg_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module asg_table import asg_pkg::*; (
  input  logic     sto,
  input  logic     rst_n,
  // APB write port
  input  logic     we,
  input  tbl_adr_t wadr,
  input  smp_t     wdat,
  // address stream in
  input  adr_stm_t adr_stm,
  output logic     adr_rdy,
  // sample stream out
  output smp_stm_t smp_stm,
  input  logic     smp_rdy,
  // soft reset strobe
  input  logic     clr
);

  smp_t mem [2**`ASG_CWM];

  logic vld_q;
  logic lst_q;
  smp_t dat_q;

  ////////////////////////////////////////////////////////////////////////////
  // waveform buffer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (we) begin
      mem[wadr] <= wdat;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read stage
  ////////////////////////////////////////////////////////////////////////////

  // take an address when empty or being drained
  assign adr_rdy = ~vld_q | smp_rdy;

  always_ff @(posedge sto) begin
    if (!rst_n || clr) begin
      vld_q <= 1'b0;
      lst_q <= 1'b0;
    end else if (adr_rdy) begin
      vld_q <= adr_stm.valid;
      lst_q <= adr_stm.last;
    end
  end

  // sample payload, held while stalled
  always_ff @(posedge sto) begin
    if (adr_rdy && adr_stm.valid) begin
      dat_q <= mem[adr_stm.adr];
    end
  end

  assign smp_stm.valid = vld_q;
  assign smp_stm.last  = lst_q;
  assign smp_stm.dat   = dat_q;

endmodule

`default_nettype wire

/* hw/asg_top.sv */
/* one channel, periodic mode, single clock; the first sample is valid two
   cycles after the trigger strobe */
`include "asg_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module asg_top import asg_pkg::*; (
  input  logic        sto,
  input  logic        rst_n,
  // APB configuration
  input  apb_adr_t    paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  // external trigger
  input  logic        trg,
  // sample stream
  output smp_stm_t    smp_stm,
  input  logic        smp_rdy
);

  cfg_t     cfg;
  evn_t     evn;
  logic     sts_str;
  logic     sts_swt;
  logic     tbl_we;
  tbl_adr_t tbl_adr;
  smp_t     tbl_dat;
  adr_stm_t adr_stm;
  logic     adr_rdy;

  ////////////////////////////////////////////////////////////////////////////
  // register block
  ////////////////////////////////////////////////////////////////////////////

  asg_apb_regs asg_apb_regs_inst (
    .sto     (sto),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .trg     (trg),
    .sts_str (sts_str),
    .sts_swt (sts_swt),
    .cfg     (cfg),
    .evn     (evn),
    .tbl_we  (tbl_we),
    .tbl_adr (tbl_adr),
    .tbl_dat (tbl_dat)
  );

  ////////////////////////////////////////////////////////////////////////////
  // pointer generator and table
  ////////////////////////////////////////////////////////////////////////////

  asg_per asg_per_inst (
    .sto     (sto),
    .rst_n   (rst_n),
    .evn     (evn),
    .cfg     (cfg),
    .adr_stm (adr_stm),
    .adr_rdy (adr_rdy),
    .sts_str (sts_str),
    .sts_swt (sts_swt)
  );

  // soft reset also flushes the read stage
  asg_table asg_table_inst (
    .sto     (sto),
    .rst_n   (rst_n),
    .we      (tbl_we),
    .wadr    (tbl_adr),
    .wdat    (tbl_dat),
    .adr_stm (adr_stm),
    .adr_rdy (adr_rdy),
    .smp_stm (smp_stm),
    .smp_rdy (smp_rdy),
    .clr     (evn.rst)
  );

endmodule

`default_nettype wire

/* verif/asg_properties.sv */
/* stream and pointer checks bound into asg_top; a beat may drop while stalled
   only on the soft reset strobe */
`include "asg_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module asg_properties import asg_pkg::*; (
  input logic     sto,
  input logic     rst_n,
  input evn_t     evn,
  input cfg_t     cfg,
  input adr_stm_t adr_stm,
  input logic     adr_rdy,
  input smp_stm_t smp_stm,
  input logic     smp_rdy,
  input logic     sts_str,
  input logic     sts_swt
);

  // failures seen so far, read by the testbench summary
  int unsigned err_cnt = 0;

  ////////////////////////////////////////////////////////////////////////////
  // stream handshakes
  ////////////////////////////////////////////////////////////////////////////

  // sample beat held until taken
  a_smp_hold: assert property (@(posedge sto) disable iff (!rst_n)
    smp_stm.valid && !smp_rdy && !evn.rst |=> smp_stm.valid && $stable(smp_stm))
    else begin
      $error("sample beat dropped or changed while stalled");
      err_cnt++;
    end

  // address beat held until taken
  a_adr_hold: assert property (@(posedge sto) disable iff (!rst_n)
    adr_stm.valid && !adr_rdy && !evn.rst |=> adr_stm.valid && $stable(adr_stm.adr))
    else begin
      $error("address beat dropped or changed while stalled");
      err_cnt++;
    end

  ////////////////////////////////////////////////////////////////////////////
  // pointer range and idle output
  ////////////////////////////////////////////////////////////////////////////

  // integer part never passes the buffer end
  a_adr_range: assert property (@(posedge sto) disable iff (!rst_n)
    adr_stm.valid |-> adr_stm.adr <= cfg.siz[$bits(ptr_t)-1 -: `ASG_CWM])
    else begin
      $error("table address beyond the siz integer part");
      err_cnt++;
    end

  // a run begins only from a start, never from a trigger alone
  a_no_start: assert property (@(posedge sto) disable iff (!rst_n)
    !sts_str && !evn.str && !sts_swt |=> !adr_stm.valid)
    else begin
      $error("address issued while not started");
      err_cnt++;
    end

  // idle run and empty output stay empty
  a_idle: assert property (@(posedge sto) disable iff (!rst_n)
    !sts_swt && !smp_stm.valid |=> !smp_stm.valid)
    else begin
      $error("sample appeared with the run idle");
      err_cnt++;
    end

endmodule

bind asg_top asg_properties asg_properties_inst (
  .sto     (sto),
  .rst_n   (rst_n),
  .evn     (evn),
  .cfg     (cfg),
  .adr_stm (adr_stm),
  .adr_rdy (adr_rdy),
  .smp_stm (smp_stm),
  .smp_rdy (smp_rdy),
  .sts_str (sts_str),
  .sts_swt (sts_swt)
);

`default_nettype wire

/* verif/asg_tb.sv */
/* runs from the project root and reads verif/asg_input.txt; table words go
   from index 0 and each test entry holds mode, siz, ste, off, count, samples */
`include "asg_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module asg_tb import asg_pkg::*; ();

  logic        sto;
  logic        rst_n;
  apb_adr_t    paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        trg;
  smp_stm_t    smp_stm;
  logic        smp_rdy;

  // raw words of the input file
  logic [31:0] vec [0:255];
  smp_t        tbl_ref [0:2**`ASG_CWM-1];
  int          tst_pos [0:7];
  int          tst_num;
  int          err_cnt;
  int          tst_cnt;
  int          bad_tst;
  int          wd_cycles;

  asg_top asg_top_inst (
    .sto     (sto),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .trg     (trg),
    .smp_stm (smp_stm),
    .smp_rdy (smp_rdy)
  );

  initial begin
    sto = 1'b0;
    forever #5 sto = ~sto;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_error(input string msg);
    err_cnt++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  task automatic finish_test(input string name, input int e0);
    tst_cnt++;
    if (err_cnt == e0) begin
      $display("test %0d %s: ok", tst_cnt, name);
    end else begin
      bad_tst++;
      $display("test %0d %s: %0d errors", tst_cnt, name, err_cnt - e0);
    end
  endtask

  // setup, access, idle; pready is tied high
  task automatic apb_write(input apb_adr_t adr, input logic [31:0] dat);
    @(negedge sto);
    paddr   = adr;
    pwrite  = 1'b1;
    pwdata  = dat;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge sto);
    penable = 1'b1;
    @(negedge sto);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input apb_adr_t adr, output logic [31:0] dat, output logic err);
    @(negedge sto);
    paddr   = adr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge sto);
    penable = 1'b1;
    // access completes at the next edge, bus still held half a cycle on
    @(negedge sto);
    dat = prdata;
    err = pslverr;
    if (pready !== 1'b1) report_error("pready low in the access phase");
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // reference pointer rule, sample k of test t
  function automatic smp_t model_smp(input int t, input int k);
    int siz;
    int ste;
    int ptr;
    siz = vec[tst_pos[t] + 1] + 1;
    ste = vec[tst_pos[t] + 2] + 1;
    ptr = vec[tst_pos[t] + 3];
    repeat (k) begin
      ptr = ptr + ste;
      if (ptr >= siz) ptr = ptr - siz;
    end
    return tbl_ref[ptr >> `ASG_CWF];
  endfunction

  // trigger, then take and compare the expected count of samples
  task automatic run_stream(input int t, output int first);
    int   cnt;
    int   got;
    int   cyc;
    logic rdy;
    smp_t exp;
    cnt   = vec[tst_pos[t] + 4];
    got   = 0;
    cyc   = 0;
    first = -1;
    @(negedge sto);
    trg = 1'b1;
    while (got < cnt) begin
      @(negedge sto);
      trg = 1'b0;
      cyc++;
      // mode 1 stalls about a third of the cycles
      rdy = (vec[tst_pos[t]] == 0) || (($urandom % 3) != 0);
      smp_rdy = rdy;
      if (smp_stm.valid && first < 0) first = cyc;
      if (smp_stm.valid && rdy) begin
        exp = vec[tst_pos[t] + 5 + got][`ASG_DW-1:0];
        if (exp !== model_smp(t, got))
          report_error($sformatf("file sample %0d disagrees with the pointer rule", got));
        if (smp_stm.dat !== exp)
          report_error($sformatf("sample %0d got %h expected %h", got, smp_stm.dat, exp));
        if (smp_stm.last)
          report_error($sformatf("sample %0d marked last before any stop", got));
        got++;
      end
    end
    smp_rdy = 1'b1;
  endtask

  // stop, then count last beats and watch for valid after the last
  task automatic stop_run(output int n_last);
    logic done;
    n_last = 0;
    done   = 1'b0;
    apb_write(CTL, 32'h4);
    repeat (8) begin
      @(negedge sto);
      if (smp_stm.valid && done) report_error("sample valid after the last beat");
      if (smp_stm.valid && smp_stm.last) begin
        n_last++;
        done = 1'b1;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge sto);
    $display("timeout: the run did not finish within %0d cycles", wd_cycles);
    $display("*** FAILED ***");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int          first;
    int          n_last;
    int          e0;
    int          p;
    int          samples;
    int          wait_cnt;
    int unsigned asrt;
    logic [31:0] rd;
    logic        er;
    rst_n     = 1'b0;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    trg       = 1'b0;
    smp_rdy   = 1'b1;
    err_cnt   = 0;
    tst_cnt   = 0;
    bad_tst   = 0;
    wd_cycles = 0;
    samples   = 0;
    void'($urandom(32'hd75d_2624));

    // locate the tests behind the table words
    $readmemh("verif/asg_input.txt", vec);
    p = 1 + vec[0];
    tst_num = vec[p];
    p++;
    for (int t = 0; t < tst_num; t++) begin
      tst_pos[t] = p;
      samples += vec[p + 4];
      p += 5 + vec[p + 4];
    end
    // 20 cycles per sample plus room for bus traffic
    wd_cycles = samples * 20 + 2000;

    repeat (8) @(negedge sto);
    rst_n = 1'b1;

    // register readback and unmapped access
    e0 = err_cnt;
    apb_write(SIZ, 32'h0001_2345);
    apb_write(STE, 32'h0002_00ff);
    apb_write(OFF, 32'hffff_ffff);
    apb_read(SIZ, rd, er);
    if (rd !== 32'h0001_2345 || er) report_error($sformatf("SIZ read %h", rd));
    apb_read(STE, rd, er);
    if (rd !== 32'h0002_00ff || er) report_error($sformatf("STE read %h", rd));
    apb_read(OFF, rd, er);
    if (rd !== 32'h0003_ffff || er) report_error($sformatf("OFF read %h", rd));
    apb_read(12'h020, rd, er);
    if (er !== 1'b1) report_error("unmapped read gave no pslverr");
    finish_test("register readback", e0);

    // waveform table
    for (int i = 0; i < vec[0]; i++) begin
      tbl_ref[i] = vec[1 + i][`ASG_DW-1:0];
      apb_write(apb_adr_t'(int'(TBL) + i), vec[1 + i]);
    end

    // streams from the file, each ended by a stop
    for (int t = 0; t < tst_num; t++) begin
      e0 = err_cnt;
      apb_write(SIZ, vec[tst_pos[t] + 1]);
      apb_write(STE, vec[tst_pos[t] + 2]);
      apb_write(OFF, vec[tst_pos[t] + 3]);
      apb_write(CTL, 32'h2);
      run_stream(t, first);
      if (t == 0 && first != 2)
        report_error($sformatf("first sample %0d cycles after trigger, expected 2", first));
      stop_run(n_last);
      if (n_last != 1) report_error($sformatf("%0d beats marked last after stop", n_last));
      finish_test($sformatf("stream %0d", t), e0);
    end

    // stopped, a trigger alone starts nothing
    e0 = err_cnt;
    apb_read(STS, rd, er);
    if (rd !== 32'h0) report_error($sformatf("STS %h after stop", rd));
    apb_write(CTL, 32'h8);
    repeat (8) begin
      @(negedge sto);
      if (smp_stm.valid) report_error("sample valid after trigger without start");
    end
    finish_test("stop and trigger without start", e0);

    // soft reset with a stalled sample in the output
    e0 = err_cnt;
    smp_rdy = 1'b0;
    apb_write(CTL, 32'ha);
    wait_cnt = 0;
    while (!smp_stm.valid && wait_cnt < 10) begin
      @(negedge sto);
      wait_cnt++;
    end
    if (!smp_stm.valid) report_error("no sample before soft reset");
    apb_read(STS, rd, er);
    if (rd !== 32'h3) report_error($sformatf("STS %h while running", rd));
    apb_write(CTL, 32'h1);
    apb_read(STS, rd, er);
    if (rd !== 32'h0) report_error($sformatf("STS %h after soft reset", rd));
    if (smp_stm.valid) report_error("sample valid after soft reset");
    p = tst_pos[tst_num - 1];
    apb_read(SIZ, rd, er);
    if (rd !== vec[p + 1]) report_error($sformatf("SIZ %h lost on soft reset", rd));
    apb_read(STE, rd, er);
    if (rd !== vec[p + 2]) report_error($sformatf("STE %h lost on soft reset", rd));
    apb_read(OFF, rd, er);
    if (rd !== vec[p + 3]) report_error($sformatf("OFF %h lost on soft reset", rd));
    smp_rdy = 1'b1;
    finish_test("soft reset", e0);

    asrt = asg_top_inst.asg_properties_inst.err_cnt;
    $display("tests %0d, failed tests %0d, errors %0d, assertion failures %0d",
             tst_cnt, bad_tst, err_cnt, asrt);
    if (err_cnt == 0 && asrt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/asg_input.txt */
// table: word count, then the words from index 0
// test count; per test: mode (1 = random ready), siz, ste, off, sample count, samples
10
0a5 1b6 2c7 3d8 4e9 5fa 70b 81c
92d a3e b4f c60 d71 e82 f93 10a4
3
// step 1.0 over 8 samples from 0
0 007ff 000ff 00000 a
0a5 1b6 2c7 3d8 4e9 5fa 70b 81c
0a5 1b6
// step 1.5 over 10 samples from 2.5
0 009ff 0017f 00280 c
2c7 4e9 5fa 81c 92d 0a5 1b6 3d8
4e9 70b 81c a3e
// same run under random ready
1 009ff 0017f 00280 e
2c7 4e9 5fa 81c 92d 0a5 1b6 3d8
4e9 70b 81c a3e 0a5 2c7

/* asg.f */
+incdir+hw
hw/asg_pkg.sv
hw/asg_apb_regs.sv
hw/asg_per.sv
hw/asg_table.sv
hw/asg_top.sv
verif/asg_properties.sv
verif/asg_tb.sv

/* Makefile */
# Verilator flow for the signal generator, run from the project root

TOP := asg_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall -Ihw hw/asg_pkg.sv hw/asg_apb_regs.sv hw/asg_per.sv \
		hw/asg_table.sv hw/asg_top.sv --top-module asg_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f asg.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
